//--- src/trace_pkg.sv
// Trace unit package with bus and counter types, register map and shared structs
package trace_pkg;

	// ******************************************************************
	// Widths that carry a meaning
	// ******************************************************************

	// Wishbone word address and data word
	typedef logic [7:0]  wb_adr_t;
	typedef logic [31:0] wb_dat_t;
	// Free-running count of qualified events
	typedef logic [15:0] event_cnt_t;

	// ******************************************************************
	// Register map, word addresses
	// ******************************************************************

	localparam wb_adr_t ADR_CTRL     = 8'd0;
	localparam wb_adr_t ADR_STATUS   = 8'd1;
	localparam wb_adr_t ADR_EVENTS   = 8'd2;
	// Buffer window, entry i lives at ADR_BUF_BASE + i
	localparam wb_adr_t ADR_BUF_BASE = 8'd64;

	// CTRL bit positions
	localparam int CTRL_ENABLE_BIT    = 0;
	localparam int CTRL_CIRCULAR_BIT  = 1;
	localparam int CTRL_ON_CHANGE_BIT = 2;
	localparam int CTRL_CLEAR_BIT     = 3;

	// STATUS bit positions
	localparam int STAT_FULL_BIT    = 0;
	localparam int STAT_WRAPPED_BIT = 1;
	localparam int STAT_INDEX_LSB   = 8;

	// ******************************************************************
	// Bundles
	// ******************************************************************

	// Master side of a Wishbone classic transfer
	typedef struct packed {
		logic    cyc;
		logic    stb;
		logic    we;
		wb_adr_t adr;
		wb_dat_t dat_w;
	} wb_req_t;

	// Slave side of a Wishbone classic transfer
	typedef struct packed {
		logic    ack;
		wb_dat_t dat_r;
	} wb_rsp_t;

	// Capture controls, clear is a single-cycle pulse
	typedef struct packed {
		logic enable;
		logic circular;
		logic on_change;
		logic clear;
	} trace_ctrl_t;

endpackage

//--- src/trace_sample_qualifier.sv
// Sample qualifier, filters probe values by capture mode and strobes kept ones to the buffer
`timescale 1ns/1ps

module trace_sample_qualifier #(
	parameter int SAMPLE_W = 16
) (
	input  logic                  clk,
	input  logic                  reset,
	input  trace_pkg::trace_ctrl_t ctrl,
	input  logic [SAMPLE_W-1:0]   probe_data,
	input  logic                  probe_valid,
	output logic                  cap_strobe,
	output logic [SAMPLE_W-1:0]   cap_data
);

	// Last value that was kept, only meaningful while have_last is set
	logic [SAMPLE_W-1:0] last_kept;
	logic                have_last;
	// Current probe value passes the capture rule
	logic                qualify;

	// ******************************************************************
	// Qualification rule
	// ******************************************************************

	// Every valid cycle in plain mode
	// Only new values in on-change mode, first value after clear always passes
	always_comb begin
		qualify = probe_valid & ctrl.enable &
			(~ctrl.on_change | ~have_last | (probe_data != last_kept));
	end

	// ******************************************************************
	// Control state
	// ******************************************************************

	always_ff @(posedge clk) begin
		if (reset || ctrl.clear) begin
			// Clear drops any sample arriving in the same cycle
			cap_strobe <= 1'b0;
			have_last  <= 1'b0;
		end else begin
			cap_strobe <= qualify;
			if (qualify) begin
				have_last <= 1'b1;
			end
		end
	end

	// Payload registers, one cycle behind the probe
	always_ff @(posedge clk) begin
		if (qualify) begin
			last_kept <= probe_data;
			cap_data  <= probe_data;
		end
	end

endmodule

//--- src/trace_buffer.sv
// Trace buffer, write-index counter over a register file with stop or circular fill
`timescale 1ns/1ps

module trace_buffer #(
	parameter int SAMPLE_W = 16,
	parameter int DEPTH    = 16
) (
	input  logic                    clk,
	input  logic                    reset,
	input  trace_pkg::trace_ctrl_t  ctrl,
	input  logic                    cap_strobe,
	input  logic [SAMPLE_W-1:0]     cap_data,
	input  logic [$clog2(DEPTH)-1:0] rd_index,
	output logic [SAMPLE_W-1:0]     rd_data,
	output logic [$clog2(DEPTH)-1:0] wr_index,
	output logic                    full,
	output logic                    wrapped,
	output trace_pkg::event_cnt_t   event_count
);

	localparam int IDX_W = $clog2(DEPTH);
	// Last entry of the buffer
	localparam logic [IDX_W-1:0] LAST_INDEX = IDX_W'(DEPTH - 1);

	// Sample storage, contents survive clear
	logic [SAMPLE_W-1:0] mem [DEPTH];
	// Strobe actually lands in the array
	logic                wr_en;

	// ******************************************************************
	// Write qualification
	// ******************************************************************

	// Stop mode stalls once full, circular always writes
	// Clear in the same cycle wins over the strobe
	always_comb begin
		wr_en = cap_strobe & ~ctrl.clear & (ctrl.circular | ~full);
	end

	// ******************************************************************
	// Write-index counter
	// ******************************************************************

	always_ff @(posedge clk) begin
		if (reset || ctrl.clear) begin
			wr_index <= '0;
			full     <= 1'b0;
			wrapped  <= 1'b0;
		end else if (wr_en) begin
			if (wr_index == LAST_INDEX) begin
				if (ctrl.circular) begin
					// Roll over and remember it happened
					wr_index <= '0;
					wrapped  <= 1'b1;
				end else begin
					// Hold on the last entry
					full <= 1'b1;
				end
			end else begin
				wr_index <= wr_index + 1'b1;
			end
		end
	end

	// ******************************************************************
	// Register file, write at wr_index, read by index
	// ******************************************************************

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_index] <= cap_data;
		end
	end

	// Asynchronous read for the bus window
	assign rd_data = mem[rd_index];

	// ******************************************************************
	// Event counter
	// ******************************************************************

	// Counts every qualified strobe, dropped ones too
	always_ff @(posedge clk) begin
		if (reset || ctrl.clear) begin
			event_count <= '0;
		end else if (cap_strobe) begin
			event_count <= event_count + 1'b1;
		end
	end

endmodule

//--- src/trace_wb_regs.sv
// Wishbone classic register slave, capture controls, status, event count and buffer window
`timescale 1ns/1ps

module trace_wb_regs #(
	parameter int SAMPLE_W = 16,
	parameter int DEPTH    = 16
) (
	input  logic                     clk,
	input  logic                     reset,
	input  trace_pkg::wb_req_t       wb_req,
	output trace_pkg::wb_rsp_t       wb_rsp,
	output trace_pkg::trace_ctrl_t   ctrl,
	input  logic                     full,
	input  logic                     wrapped,
	input  logic [$clog2(DEPTH)-1:0] wr_index,
	input  trace_pkg::event_cnt_t    event_count,
	output logic [$clog2(DEPTH)-1:0] rd_index,
	input  logic [SAMPLE_W-1:0]      rd_data
);

	import trace_pkg::*;

	localparam int IDX_W = $clog2(DEPTH);
	// Top word address of the buffer window
	localparam wb_adr_t WIN_LAST = ADR_BUF_BASE + wb_adr_t'(DEPTH - 1);

	// New request, not yet answered
	logic    req_new;
	// CTRL write in this cycle
	logic    ctrl_wr;
	// Address falls in the buffer window
	logic    in_window;
	// Read mux result
	wb_dat_t rd_word;
	// Registered response
	logic    ack_q;
	wb_dat_t dat_q;

	// ******************************************************************
	// Request decode
	// ******************************************************************

	// Ack high blocks a second answer to the same held request
	assign req_new   = wb_req.cyc & wb_req.stb & ~ack_q;
	assign ctrl_wr   = req_new & wb_req.we & (wb_req.adr == ADR_CTRL);
	assign in_window = (wb_req.adr >= ADR_BUF_BASE) && (wb_req.adr <= WIN_LAST);

	// Window base is aligned, so the low bits are the entry index
	assign rd_index = wb_req.adr[IDX_W-1:0];

	// ******************************************************************
	// Read mux
	// ******************************************************************

	always_comb begin
		rd_word = '0;
		if (in_window) begin
			rd_word = wb_dat_t'(rd_data);
		end else begin
			case (wb_req.adr)
				ADR_CTRL: begin
					// Clear bit reads back as 0
					rd_word[CTRL_ENABLE_BIT]    = ctrl.enable;
					rd_word[CTRL_CIRCULAR_BIT]  = ctrl.circular;
					rd_word[CTRL_ON_CHANGE_BIT] = ctrl.on_change;
				end
				ADR_STATUS: begin
					rd_word[STAT_FULL_BIT]              = full;
					rd_word[STAT_WRAPPED_BIT]           = wrapped;
					rd_word[STAT_INDEX_LSB +: IDX_W]    = wr_index;
				end
				ADR_EVENTS: begin
					rd_word = wb_dat_t'(event_count);
				end
				// Unmapped addresses read 0
				default: rd_word = '0;
			endcase
		end
	end

	// ******************************************************************
	// Control register and clear pulse
	// ******************************************************************

	always_ff @(posedge clk) begin
		if (reset) begin
			ctrl <= '0;
		end else begin
			// Clear lasts one cycle unless rewritten
			ctrl.clear <= 1'b0;
			if (ctrl_wr) begin
				ctrl.enable    <= wb_req.dat_w[CTRL_ENABLE_BIT];
				ctrl.circular  <= wb_req.dat_w[CTRL_CIRCULAR_BIT];
				ctrl.on_change <= wb_req.dat_w[CTRL_ON_CHANGE_BIT];
				ctrl.clear     <= wb_req.dat_w[CTRL_CLEAR_BIT];
			end
		end
	end

	// ******************************************************************
	// Response, single-cycle ack with registered data
	// ******************************************************************

	always_ff @(posedge clk) begin
		if (reset) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= req_new;
		end
	end

	// Writes to read-only words just get the ack
	always_ff @(posedge clk) begin
		if (req_new) begin
			dat_q <= rd_word;
		end
	end

	always_comb begin
		wb_rsp.ack   = ack_q;
		wb_rsp.dat_r = dat_q;
	end

endmodule

//--- src/trace_unit_top.sv
// Signal trace unit top, probe qualifier feeding a trace buffer read over Wishbone
`timescale 1ns/1ps

module trace_unit_top #(
	parameter int SAMPLE_W = 16,
	parameter int DEPTH    = 16
) (
	input  logic                clk,
	input  logic                reset,
	input  logic [SAMPLE_W-1:0] probe_data,
	input  logic                probe_valid,
	input  trace_pkg::wb_req_t  wb_req,
	output trace_pkg::wb_rsp_t  wb_rsp
);

	import trace_pkg::*;

	localparam int IDX_W = $clog2(DEPTH);

	// Controls from the register slave
	trace_ctrl_t         ctrl;
	// Qualified samples towards the buffer
	logic                cap_strobe;
	logic [SAMPLE_W-1:0] cap_data;
	// Buffer state back to the slave
	logic [IDX_W-1:0]    rd_index;
	logic [SAMPLE_W-1:0] rd_data;
	logic [IDX_W-1:0]    wr_index;
	logic                full;
	logic                wrapped;
	event_cnt_t          event_count;

	// Probe side
	trace_sample_qualifier #(
		.SAMPLE_W(SAMPLE_W)
	) u_qualifier (
		.clk        (clk),
		.reset      (reset),
		.ctrl       (ctrl),
		.probe_data (probe_data),
		.probe_valid(probe_valid),
		.cap_strobe (cap_strobe),
		.cap_data   (cap_data)
	);

	// Storage and counters
	trace_buffer #(
		.SAMPLE_W(SAMPLE_W),
		.DEPTH   (DEPTH)
	) u_buffer (
		.clk        (clk),
		.reset      (reset),
		.ctrl       (ctrl),
		.cap_strobe (cap_strobe),
		.cap_data   (cap_data),
		.rd_index   (rd_index),
		.rd_data    (rd_data),
		.wr_index   (wr_index),
		.full       (full),
		.wrapped    (wrapped),
		.event_count(event_count)
	);

	// Host side
	trace_wb_regs #(
		.SAMPLE_W(SAMPLE_W),
		.DEPTH   (DEPTH)
	) u_regs (
		.clk        (clk),
		.reset      (reset),
		.wb_req     (wb_req),
		.wb_rsp     (wb_rsp),
		.ctrl       (ctrl),
		.full       (full),
		.wrapped    (wrapped),
		.wr_index   (wr_index),
		.event_count(event_count),
		.rd_index   (rd_index),
		.rd_data    (rd_data)
	);

endmodule

//--- verif/tb_trace_unit.sv
// Trace unit testbench driving probe bursts and checking registers and buffer over Wishbone
`timescale 1ns/1ps

module tb_trace_unit;

	import trace_pkg::*;

	localparam int SAMPLE_W    = 16;
	localparam int DEPTH       = 16;
	localparam int IDX_W       = $clog2(DEPTH);
	localparam int ACK_TIMEOUT = 20;

	logic                clk;
	logic                reset;
	logic [SAMPLE_W-1:0] probe_data;
	logic                probe_valid;
	wb_req_t             wb_req;
	wb_rsp_t             wb_rsp;

	// Error and ack bookkeeping
	int          mismatch_count = 0;
	int          other_count    = 0;
	int          access_count   = 0;
	int          ack_count      = 0;
	logic        ack_prev       = 1'b0;
	logic [31:0] lcg_state;

	// Reference model of qualifier and buffer
	logic                mdl_enable;
	logic                mdl_circular;
	logic                mdl_on_change;
	logic                mdl_have_last;
	logic [SAMPLE_W-1:0] mdl_last;
	logic [SAMPLE_W-1:0] mdl_mem [DEPTH];
	logic                mdl_written [DEPTH];
	int                  mdl_index;
	logic                mdl_full;
	logic                mdl_wrapped;
	int                  mdl_events;

	// Expected read data in issue order
	wb_dat_t exp_q [$];
	string   name_q [$];
	wb_dat_t cmp_exp;
	string   cmp_name;

	trace_unit_top u_trace_unit_top (
		.clk        (clk),
		.reset      (reset),
		.probe_data (probe_data),
		.probe_valid(probe_valid),
		.wb_req     (wb_req),
		.wb_rsp     (wb_rsp)
	);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	// **********************************************************************
	// Reference model
	// **********************************************************************

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic void model_clear();
		mdl_index     = 0;
		mdl_full      = 1'b0;
		mdl_wrapped   = 1'b0;
		mdl_events    = 0;
		mdl_have_last = 1'b0;
	endfunction

	// Qualify one valid probe value and then write or drop it
	function automatic void model_sample(input logic [SAMPLE_W-1:0] v);
		if (mdl_enable && (!mdl_on_change || !mdl_have_last || v != mdl_last)) begin
			mdl_events    = mdl_events + 1;
			mdl_have_last = 1'b1;
			mdl_last      = v;
			if (mdl_circular || !mdl_full) begin
				mdl_mem[mdl_index]     = v;
				mdl_written[mdl_index] = 1'b1;
				if (mdl_index == DEPTH - 1) begin
					// Wrap in circular mode or hold on the last entry
					if (mdl_circular) begin
						mdl_index   = 0;
						mdl_wrapped = 1'b1;
					end else begin
						mdl_full = 1'b1;
					end
				end else begin
					mdl_index = mdl_index + 1;
				end
			end
		end
	endfunction

	// STATUS holds full and wrapped in the low bits and the index from bit 8
	function automatic wb_dat_t exp_status();
		wb_dat_t s;
		s = '0;
		s[STAT_FULL_BIT]             = mdl_full;
		s[STAT_WRAPPED_BIT]          = mdl_wrapped;
		s[STAT_INDEX_LSB +: IDX_W]   = IDX_W'(mdl_index);
		return s;
	endfunction

	function automatic wb_dat_t exp_ctrl();
		wb_dat_t c;
		c = '0;
		c[CTRL_ENABLE_BIT]    = mdl_enable;
		c[CTRL_CIRCULAR_BIT]  = mdl_circular;
		c[CTRL_ON_CHANGE_BIT] = mdl_on_change;
		return c;
	endfunction

	// **********************************************************************
	// Compare process with one check per read ack
	// **********************************************************************

	always @(posedge clk) begin
		if (wb_rsp.ack) begin
			ack_count = ack_count + 1;
			if (ack_prev) begin
				other_count = other_count + 1;
				$display("Error at %0t: ack stayed high for two cycles", $time);
			end
			if (!wb_req.we) begin
				if (exp_q.size() == 0) begin
					other_count = other_count + 1;
					$display("Error at %0t: read ack with no read pending", $time);
				end else begin
					cmp_exp  = exp_q.pop_front();
					cmp_name = name_q.pop_front();
					if (wb_rsp.dat_r !== cmp_exp) begin
						mismatch_count = mismatch_count + 1;
						$display("Mismatch at %0t: %s expected %h, read %h",
							$time, cmp_name, cmp_exp, wb_rsp.dat_r);
					end
				end
			end
		end
		ack_prev = wb_rsp.ack;
	end

	// **********************************************************************
	// Wishbone master and probe tasks
	// **********************************************************************

	task automatic finish_run();
		$display("Error counts: %0d mismatches, %0d other failures",
			mismatch_count, other_count);
		if (mismatch_count == 0 && other_count == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	endtask

	// Hold the request until ack and release it on the ack edge
	task automatic wait_ack(input wb_adr_t adr);
		int cycles;
		cycles = 0;
		@(posedge clk);
		while (!wb_rsp.ack && cycles < ACK_TIMEOUT) begin
			cycles = cycles + 1;
			@(posedge clk);
		end
		if (!wb_rsp.ack) begin
			other_count = other_count + 1;
			$display("Timeout: no Wishbone ack for address %h", adr);
			finish_run();
		end else begin
			wb_req.cyc <= 1'b0;
			wb_req.stb <= 1'b0;
			wb_req.we  <= 1'b0;
		end
	endtask

	task automatic wb_write(input wb_adr_t adr, input wb_dat_t dat);
		@(posedge clk);
		wb_req.cyc   <= 1'b1;
		wb_req.stb   <= 1'b1;
		wb_req.we    <= 1'b1;
		wb_req.adr   <= adr;
		wb_req.dat_w <= dat;
		access_count = access_count + 1;
		wait_ack(adr);
	endtask

	task automatic wb_read(input wb_adr_t adr, input wb_dat_t exp, input string name);
		@(posedge clk);
		exp_q.push_back(exp);
		name_q.push_back(name);
		wb_req.cyc <= 1'b1;
		wb_req.stb <= 1'b1;
		wb_req.we  <= 1'b0;
		wb_req.adr <= adr;
		access_count = access_count + 1;
		wait_ack(adr);
	endtask

	// Mode change where a clear pulse also resets the model
	task automatic write_ctrl(input logic en, input logic circ, input logic chg, input logic clr);
		wb_dat_t d;
		d = '0;
		d[CTRL_ENABLE_BIT]    = en;
		d[CTRL_CIRCULAR_BIT]  = circ;
		d[CTRL_ON_CHANGE_BIT] = chg;
		d[CTRL_CLEAR_BIT]     = clr;
		mdl_enable    = en;
		mdl_circular  = circ;
		mdl_on_change = chg;
		if (clr) begin
			model_clear();
		end
		wb_write(ADR_CTRL, d);
	endtask

	task automatic drive_sample(input logic [SAMPLE_W-1:0] v);
		@(posedge clk);
		probe_data  <= v;
		probe_valid <= 1'b1;
		model_sample(v);
	endtask

	// Drop valid and let the last sample settle before reading
	task automatic end_burst();
		@(posedge clk);
		probe_valid <= 1'b0;
		repeat (2) @(posedge clk);
	endtask

	task automatic check_state();
		int i;
		wb_read(ADR_STATUS, exp_status(), "STATUS");
		wb_read(ADR_EVENTS, wb_dat_t'(mdl_events), "EVENTS");
		for (i = 0; i < DEPTH; i++) begin
			if (mdl_written[i]) begin
				wb_read(ADR_BUF_BASE + wb_adr_t'(i), wb_dat_t'(mdl_mem[i]),
					$sformatf("buffer[%0d]", i));
			end
		end
	endtask

	// **********************************************************************
	// Test sequence
	// **********************************************************************

	initial begin
		int i;
		int reps;
		logic [SAMPLE_W-1:0] v;
		reset       <= 1'b1;
		probe_data  <= '0;
		probe_valid <= 1'b0;
		wb_req      <= '0;
		lcg_state = 32'h75876570;
		for (i = 0; i < DEPTH; i++) begin
			mdl_written[i] = 1'b0;
		end
		mdl_enable    = 1'b0;
		mdl_circular  = 1'b0;
		mdl_on_change = 1'b0;
		mdl_last      = '0;
		model_clear();
		repeat (3) @(posedge clk);
		reset <= 1'b0;

		// Reset values and no capture while disabled
		wb_read(ADR_CTRL, exp_ctrl(), "CTRL");
		for (i = 0; i < 5; i++) begin
			drive_sample(SAMPLE_W'(lcg_next() >> 16));
		end
		end_burst();
		check_state();

		// Stop mode with 20 samples into 16 entries
		write_ctrl(1'b1, 1'b0, 1'b0, 1'b1);
		for (i = 0; i < 20; i++) begin
			drive_sample(SAMPLE_W'(lcg_next() >> 16));
		end
		end_burst();
		check_state();

		// On-change mode with runs of two or three repeated values
		write_ctrl(1'b1, 1'b0, 1'b1, 1'b1);
		for (i = 0; i < 8; i++) begin
			v    = SAMPLE_W'(lcg_next() >> 16);
			reps = 2 + int'(lcg_next() % 2);
			repeat (reps) drive_sample(v);
		end
		end_burst();
		check_state();

		// Circular mode with 21 samples
		write_ctrl(1'b1, 1'b1, 1'b0, 1'b1);
		for (i = 0; i < 21; i++) begin
			drive_sample(SAMPLE_W'(lcg_next() >> 16));
		end
		end_burst();
		wb_read(ADR_CTRL, exp_ctrl(), "CTRL");
		check_state();

		// Clear keeps contents and a new capture starts from index 0
		write_ctrl(1'b0, 1'b0, 1'b0, 1'b1);
		check_state();
		write_ctrl(1'b1, 1'b0, 1'b0, 1'b0);
		for (i = 0; i < 3; i++) begin
			drive_sample(SAMPLE_W'(lcg_next() >> 16));
		end
		end_burst();
		check_state();

		// Unmapped reads and writes to read-only words
		wb_read(8'd3, '0, "unmapped 0x03");
		wb_read(ADR_BUF_BASE + wb_adr_t'(DEPTH), '0, "unmapped past window");
		wb_read(8'hFF, '0, "unmapped 0xFF");
		wb_write(ADR_STATUS, 32'hFFFF_FFFF);
		wb_write(ADR_EVENTS, 32'hFFFF_FFFF);
		wb_read(ADR_CTRL, exp_ctrl(), "CTRL");
		check_state();

		// Let the compare process count the last ack
		@(posedge clk);
		if (ack_count != access_count) begin
			other_count = other_count + 1;
			$display("Error: %0d accesses got %0d acks", access_count, ack_count);
		end
		finish_run();
	end

endmodule

//--- build.f
src/trace_pkg.sv
src/trace_sample_qualifier.sv
src/trace_buffer.sv
src/trace_wb_regs.sv
src/trace_unit_top.sv
verif/tb_trace_unit.sv

//--- Makefile
# Verilator flow for the trace unit testbench

TOP := tb_trace_unit

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal -f build.f --top-module $(TOP) -o sim_$(TOP)

run: compile
	./obj_dir/sim_$(TOP) | tee run.log
	@if grep -q "Finished with errors" run.log; then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "Finished with no errors" run.log; then echo "No pass line in run.log"; exit 1; fi
	@echo "Simulation PASSED"

clean:
	rm -rf obj_dir run.log
